/* vlog.f */
rtl/raster_pkg.sv
rtl/div_rasterizer.sv
rtl/edge_delta.sv
rtl/slope_format.sv
rtl/edge_slope_top.sv
testbench/tb_edge_slope.sv

/* Makefile */
TOP = tb_edge_slope

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir

/* testbench/tb_edge_slope.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_edge_slope;

    import raster_pkg::*;

    localparam int EDGES   = 400;
    localparam int MAX_CYC = EDGES * 3 * 4 + 100;

    typedef enum {GENERAL, ORDERING, HORIZONTAL, SATURATION, BACKPRESSURE} kind_t;

    logic   aclk;
    logic   aresetn;
    logic   edge_valid;
    edge_t  edge_data;
    logic   edge_ready;
    logic   slope_valid;
    slope_t slope;
    logic   slope_ready;

    // Expected records in transfer order, with a flag for bottom-first twins
    slope_t exp_q[$];
    bit     twin_q[$];
    slope_t last_exp;
    edge_t  twin_src;
    int     errors;
    int     total_errors;
    int     failed_tests;
    int     cycle_count;
    string  test_name;

    edge_slope_top i_edge_slope_top (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .edge_valid  (edge_valid),
        .edge_data   (edge_data),
        .edge_ready  (edge_ready),
        .slope_valid (slope_valid),
        .slope       (slope),
        .slope_ready (slope_ready)
    );

    always #50 aclk = ~aclk;

    // Watchdog restarted by every test
    always @(posedge aclk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > MAX_CYC) begin
            $display("Timeout: test %s did not finish within %0d cycles", test_name, MAX_CYC);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic slope_t model_slope(edge_t e);
        slope_t r;
        longint xa, ya, xb, yb, xt, yt, dx, dy, adx, q;
        xa = $signed(e.x0);
        ya = $signed(e.y0);
        xb = $signed(e.x1);
        yb = $signed(e.y1);
        r = '0;
        r.swapped = (yb < ya);
        xt = r.swapped ? xb : xa;
        yt = r.swapped ? yb : ya;
        dx = (r.swapped ? xa : xb) - xt;
        dy = (r.swapped ? ya : yb) - yt;
        r.x_start  = xt[15:0];
        r.y_top    = yt[15:0];
        r.y_bottom = (r.swapped ? ya[15:0] : yb[15:0]);
        if (dy == 0) begin
            r.horizontal = 1'b1;
        end else begin
            adx = (dx < 0) ? -dx : dx;
            q = (adx * 65536) / dy;
            if (q > 64'sd2147483647) begin
                q = 64'sd2147483647;
            end
            r.slope = 32'((dx < 0) ? -q : q);
        end
        return r;
    endfunction

    // Half small coordinates so moderate slopes show up often
    function automatic logic [15:0] rand_coord();
        if ($urandom_range(1, 0) == 1) begin
            return 16'($urandom);
        end
        return 16'($urandom_range(127, 0) - 64);
    endfunction

    function automatic edge_t make_edge(kind_t kind, int n);
        edge_t e;
        int    xl;
        int    xr;
        int    yl;
        e.x0 = rand_coord();
        e.y0 = rand_coord();
        e.x1 = rand_coord();
        e.y1 = rand_coord();
        case (kind)
            ORDERING: begin
                if (n % 2 == 1) begin
                    e.x0 = twin_src.x1;
                    e.y0 = twin_src.y1;
                    e.x1 = twin_src.x0;
                    e.y1 = twin_src.y0;
                    return e;
                end
                while (e.y0 == e.y1)
                    e.y1 = rand_coord();
                if (e.y1 < e.y0) begin
                    e = {e.x1, e.y1, e.x0, e.y0};
                end
                twin_src = e;
            end
            HORIZONTAL: e.y1 = e.y0;
            SATURATION: begin
                // |dx| at least 32768 over one scanline
                xl = -32768 + int'($urandom_range(32767, 0));
                xr = xl + 32768 + int'($urandom_range(-xl - 1, 0));
                yl = -32768 + int'($urandom_range(65534, 0));
                e.x0 = 16'(($urandom_range(1, 0) == 1) ? xl : xr);
                e.x1 = 16'((e.x0 == 16'(xl)) ? xr : xl);
                e.y0 = 16'(($urandom_range(1, 0) == 1) ? yl : yl + 1);
                e.y1 = 16'((e.y0 == 16'(yl)) ? yl + 1 : yl);
            end
            default: begin
                while (e.y0 == e.y1)
                    e.y1 = rand_coord();
            end
        endcase
        return e;
    endfunction

    task automatic check_idle();
        assert (!slope_valid && edge_ready) else begin
            $display("** Error: RESET expected valid 0 ready 1, actual valid %b ready %b",
                slope_valid, edge_ready);
            errors++;
        end
    endtask

    task automatic reset_test();
        errors = 0;
        test_name = "RESET";
        cycle_count = 0;
        aresetn = 1'b0;
        repeat (8) begin
            @(negedge aclk);
            check_idle();
        end
        aresetn = 1'b1;
        repeat (2) begin
            @(negedge aclk);
            check_idle();
        end
        $display("RESET: %0d errors", errors);
        total_errors += errors;
        if (errors != 0) begin
            failed_tests++;
        end
    endtask

    task automatic run_test(kind_t kind, int stall_pct, int gap_pct);
        int     offered;
        int     got;
        bit     taken;
        bit     held;
        bit     twin;
        slope_t hold_val;
        slope_t exp_s;
        errors = 0;
        offered = 0;
        got = 0;
        taken = 0;
        held = 0;
        test_name = kind.name();
        cycle_count = 0;
        while (got < EDGES) begin
            @(negedge aclk);
            // A slope that waited must still be there, unchanged
            if (held) begin
                assert (slope_valid && slope == hold_val) else begin
                    $display("** Error: %s held slope expected %h actual %h (valid %b)",
                        test_name, hold_val, slope, slope_valid);
                    errors++;
                end
            end
            if (taken) begin
                edge_valid = 1'b0;
            end
            if (!edge_valid && offered < EDGES && $urandom_range(99, 0) >= gap_pct) begin
                edge_data = make_edge(kind, offered);
                edge_valid = 1'b1;
                offered++;
            end
            slope_ready = ($urandom_range(99, 0) >= stall_pct);
            #1;
            // Handshakes that the next rising edge will complete
            taken = edge_valid && edge_ready;
            if (taken) begin
                exp_q.push_back(model_slope(edge_data));
                twin_q.push_back(kind == ORDERING && offered % 2 == 0);
            end
            held = slope_valid && !slope_ready;
            hold_val = slope;
            if (slope_valid && slope_ready) begin
                assert (exp_q.size() != 0) else begin
                    $display("Test %s: a slope came out with no edge outstanding", test_name);
                    errors++;
                end
                if (exp_q.size() != 0) begin
                    exp_s = exp_q.pop_front();
                    twin = twin_q.pop_front();
                    assert (slope == exp_s) else begin
                        $display("** Error: %s expected %h actual %h", test_name, exp_s, slope);
                        errors++;
                    end
                    // Bottom-first twin matches its top-first source apart from swapped
                    if (twin) begin
                        last_exp.swapped = 1'b1;
                        assert (slope == last_exp) else begin
                            $display("** Error: %s twin expected %h actual %h",
                                test_name, last_exp, slope);
                            errors++;
                        end
                    end
                    last_exp = exp_s;
                end
                got++;
            end
        end
        assert (exp_q.size() == 0) else begin
            $display("Test %s: %0d edges never came out", test_name, exp_q.size());
            errors++;
        end
        $display("%s: %0d edges, %0d errors", test_name, EDGES, errors);
        total_errors += errors;
        if (errors != 0) begin
            failed_tests++;
        end
    endtask

    initial begin
        void'($urandom(58869));
        aclk = 1'b0;
        aresetn = 1'b0;
        edge_valid = 1'b0;
        edge_data = '0;
        slope_ready = 1'b0;
        cycle_count = 0;
        errors = 0;
        total_errors = 0;
        failed_tests = 0;
        test_name = "RESET";
        reset_test();
        run_test(GENERAL, 20, 30);
        run_test(ORDERING, 20, 30);
        run_test(HORIZONTAL, 20, 30);
        run_test(SATURATION, 20, 30);
        run_test(BACKPRESSURE, 70, 10);
        $display("tests 6, failed %0d, errors %0d", failed_tests, total_errors);
        if (failed_tests == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/edge_slope_top.sv */
`timescale 1ns/1ps
`default_nettype none

module edge_slope_top (
    input  logic               aclk,
    input  logic               aresetn,

    input  logic               edge_valid,
    input  raster_pkg::edge_t  edge_data,
    output logic               edge_ready,

    output logic               slope_valid,
    output raster_pkg::slope_t slope,
    input  logic               slope_ready
);

    import raster_pkg::*;

    // Operands toward the divider
    logic [63:0] dividend;
    logic [63:0] divisor;
    logic        op_valid;
    logic        divisor_ready;
    logic        dividend_ready;

    // Tag path around the divider
    logic        tag_push;
    edge_tag_t   tag;

    // Divider result
    logic [87:0] dout;
    logic        dout_valid;
    logic        dout_ready;
    logic        dbz;

    edge_delta i_edge_delta (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .edge_valid     (edge_valid),
        .edge_data      (edge_data),
        .edge_ready     (edge_ready),
        .dividend       (dividend),
        .divisor        (divisor),
        .op_valid       (op_valid),
        .divisor_ready  (divisor_ready),
        .dividend_ready (dividend_ready),
        .tag_push       (tag_push),
        .tag            (tag)
    );

    // Common valid drives both operand streams
    div_rasterizer i_div_rasterizer (
        .aclk                   (aclk),
        .aresetn                (aresetn),
        .s_axis_divisor_tdata   (divisor),
        .s_axis_divisor_tvalid  (op_valid),
        .s_axis_divisor_tready  (divisor_ready),
        .s_axis_dividend_tdata  (dividend),
        .s_axis_dividend_tvalid (op_valid),
        .s_axis_dividend_tready (dividend_ready),
        .m_axis_dout_tdata      (dout),
        .m_axis_dout_tvalid     (dout_valid),
        .m_axis_dout_tuser      (dbz),
        .m_axis_dout_tready     (dout_ready)
    );

    slope_format i_slope_format (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .tag_push    (tag_push),
        .tag         (tag),
        .dout        (dout),
        .dout_valid  (dout_valid),
        .dbz         (dbz),
        .dout_ready  (dout_ready),
        .slope_valid (slope_valid),
        .slope       (slope),
        .slope_ready (slope_ready)
    );

endmodule

`default_nettype wire

/* rtl/slope_format.sv */
`timescale 1ns/1ps
`default_nettype none

module slope_format (
    input  logic                  aclk,
    input  logic                  aresetn,

    input  logic                  tag_push,
    input  raster_pkg::edge_tag_t tag,

    input  logic [87:0]           dout,
    input  logic                  dout_valid,
    input  logic                  dbz,
    output logic                  dout_ready,

    output logic                  slope_valid,
    output raster_pkg::slope_t    slope,
    input  logic                  slope_ready
);

    import raster_pkg::*;

    edge_tag_t             tag_mem [TAG_DEPTH];
    logic [TAG_PTR_W-1:0]  wr_ptr;
    logic [TAG_PTR_W-1:0]  rd_ptr;
    logic [TAG_PTR_W:0]    count;
    logic                  full;
    logic                  empty;
    logic                  pop;
    edge_tag_t             head;
    logic [QUOT_W-1:0]     quot;
    logic [SLOPE_W-1:0]    mag;
    logic [SLOPE_W-1:0]    signed_mag;
    slope_t                slope_d;

    assign full  = (count == (TAG_PTR_W+1)'(TAG_DEPTH));
    assign empty = (count == '0);

    assign dout_ready = !slope_valid || slope_ready;
    assign pop        = dout_valid && dout_ready;

    // Tag queue, oldest entry pairs with the next quotient
    always_ff @(posedge aclk) begin
        if (tag_push) begin
            tag_mem[wr_ptr] <= tag;
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (tag_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({tag_push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head = tag_mem[rd_ptr];
    assign quot = dout[QUOT_W-1:0];

    // Clamp the magnitude, then restore the sign of dx
    always_comb begin
        if (quot > QUOT_W'(SLOPE_MAX)) begin
            mag = SLOPE_MAX;
        end else begin
            mag = quot[SLOPE_W-1:0];
        end
        signed_mag = head.neg ? -mag : mag;
    end

    // Zero dy means a horizontal edge
    always_comb begin
        slope_d.slope      = dbz ? '0 : signed_mag;
        slope_d.x_start    = head.x_start;
        slope_d.y_top      = head.y_top;
        slope_d.y_bottom   = head.y_bottom;
        slope_d.swapped    = head.swapped;
        slope_d.horizontal = dbz;
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            slope_valid <= 1'b0;
        end else if (dout_ready) begin
            slope_valid <= dout_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (pop) begin
            slope <= slope_d;
        end
    end

    // In-flight count bounds the queue on both sides
    a_no_overflow: assert property (@(posedge aclk) disable iff (!aresetn)
        tag_push |-> !full);

    a_no_underflow: assert property (@(posedge aclk) disable iff (!aresetn)
        pop |-> !empty);

endmodule

`default_nettype wire

/* rtl/edge_delta.sv */
`timescale 1ns/1ps
`default_nettype none

module edge_delta (
    input  logic                  aclk,
    input  logic                  aresetn,

    input  logic                  edge_valid,
    input  raster_pkg::edge_t     edge_data,
    output logic                  edge_ready,

    output logic [63:0]           dividend,
    output logic [63:0]           divisor,
    output logic                  op_valid,
    input  logic                  divisor_ready,
    input  logic                  dividend_ready,

    output logic                  tag_push,
    output raster_pkg::edge_tag_t tag
);

    import raster_pkg::*;

    logic                      swap;
    logic signed [COORD_W-1:0] x_top;
    logic signed [COORD_W-1:0] y_top;
    logic signed [COORD_W-1:0] x_bot;
    logic signed [COORD_W-1:0] y_bot;
    logic signed [DELTA_W-1:0] dx;
    logic        [DELTA_W-1:0] dx_abs;
    logic        [DELTA_W-1:0] dy;
    logic                      op_take;
    logic                      edge_take;
    edge_tag_t                 tag_d;
    logic [63:0]               dividend_d;
    logic [63:0]               divisor_d;

    // Top vertex is the one with the smaller y
    always_comb begin
        swap = (edge_data.y1 < edge_data.y0);
        if (swap) begin
            x_top = edge_data.x1;
            y_top = edge_data.y1;
            x_bot = edge_data.x0;
            y_bot = edge_data.y0;
        end else begin
            x_top = edge_data.x0;
            y_top = edge_data.y0;
            x_bot = edge_data.x1;
            y_bot = edge_data.y1;
        end
    end

    // One extra bit so full-range differences cannot wrap
    always_comb begin
        dx     = {x_bot[COORD_W-1], x_bot} - {x_top[COORD_W-1], x_top};
        dy     = {y_bot[COORD_W-1], y_bot} - {y_top[COORD_W-1], y_top};
        dx_abs = dx[DELTA_W-1] ? -dx : dx;
    end

    always_comb begin
        dividend_d       = 64'(dx_abs) << FRAC_BITS;
        divisor_d        = 64'(dy);
        tag_d.neg        = dx[DELTA_W-1];
        tag_d.swapped    = swap;
        tag_d.x_start    = x_top;
        tag_d.y_top      = y_top;
        tag_d.y_bottom   = y_bot;
    end

    // Divider takes both operands in the same cycle
    assign op_take    = op_valid && divisor_ready && dividend_ready;
    assign edge_ready = !op_valid || op_take;
    assign edge_take  = edge_valid && edge_ready;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            op_valid <= 1'b0;
        end else if (edge_ready) begin
            op_valid <= edge_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (edge_take) begin
            dividend <= dividend_d;
            divisor  <= divisor_d;
            tag      <= tag_d;
        end
    end

    // Tag enters the format queue with its operands
    assign tag_push = op_take;

    a_op_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        op_valid && !(divisor_ready && dividend_ready) |=>
            op_valid && $stable(dividend) && $stable(divisor) && $stable(tag));

endmodule

`default_nettype wire

/* rtl/div_rasterizer.sv */
`timescale 1ns/1ps
`default_nettype none

module div_rasterizer (
    input  logic        aclk,
    input  logic        aresetn,

    // Divisor operand
    input  logic [63:0] s_axis_divisor_tdata,
    input  logic        s_axis_divisor_tvalid,
    output logic        s_axis_divisor_tready,

    // Dividend operand
    input  logic [63:0] s_axis_dividend_tdata,
    input  logic        s_axis_dividend_tvalid,
    output logic        s_axis_dividend_tready,

    // Result, tuser carries divide by zero
    output logic [87:0] m_axis_dout_tdata,
    output logic        m_axis_dout_tvalid,
    output logic        m_axis_dout_tuser,
    input  logic        m_axis_dout_tready
);

    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        OUT
    } state_t;

    state_t      state;
    state_t      state_nxt;
    logic        op_take;
    logic [63:0] divisor_r;
    logic [63:0] dividend_r;
    logic [63:0] quot;
    logic [63:0] rem;
    logic [43:0] quot_r;
    logic [43:0] rem_r;
    logic        dbz_r;

    assign s_axis_divisor_tready  = (state == IDLE);
    assign s_axis_dividend_tready = (state == IDLE);

    // Both streams move together
    assign op_take = (state == IDLE) && s_axis_divisor_tvalid && s_axis_dividend_tvalid;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        unique case (state)
            IDLE: if (op_take) state_nxt = BUSY;
            BUSY: state_nxt = OUT;
            OUT:  if (m_axis_dout_tready) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (op_take) begin
            divisor_r  <= s_axis_divisor_tdata;
            dividend_r <= s_axis_dividend_tdata;
        end
    end

    // Zero divisor passes the dividend through as remainder
    always_comb begin
        if (divisor_r == 64'd0) begin
            quot = 64'd0;
            rem  = dividend_r;
        end else begin
            quot = dividend_r / divisor_r;
            rem  = dividend_r % divisor_r;
        end
    end

    // Result captured during BUSY, held through OUT
    always_ff @(posedge aclk) begin
        if (state == BUSY) begin
            quot_r <= quot[43:0];
            rem_r  <= rem[43:0];
            dbz_r  <= (divisor_r == 64'd0);
        end
    end

    assign m_axis_dout_tdata  = {rem_r, quot_r};
    assign m_axis_dout_tvalid = (state == OUT);
    assign m_axis_dout_tuser  = dbz_r;

    // A pending result must not drop or change before it is taken
    a_dout_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        m_axis_dout_tvalid && !m_axis_dout_tready |=>
            m_axis_dout_tvalid && $stable(m_axis_dout_tdata) && $stable(m_axis_dout_tuser));

endmodule

`default_nettype wire

/* rtl/raster_pkg.sv */
`default_nettype none

package raster_pkg;

    // Vertex coordinates are plain signed integers
    localparam int COORD_W   = 16;
    localparam int DELTA_W   = COORD_W + 1;

    // Slope is signed Q16.16
    localparam int FRAC_BITS = 16;
    localparam int SLOPE_W   = 32;

    // Quotient field width in the divider result word
    localparam int QUOT_W    = 44;

    // Tags waiting for their quotient; three can be in flight
    localparam int TAG_DEPTH = 4;
    localparam int TAG_PTR_W = $clog2(TAG_DEPTH);

    // Largest representable slope magnitude
    localparam logic [SLOPE_W-1:0] SLOPE_MAX = 32'h7fff_ffff;

    // One edge as two vertices, in the order received
    typedef struct packed {
        logic signed [COORD_W-1:0] x0;
        logic signed [COORD_W-1:0] y0;
        logic signed [COORD_W-1:0] x1;
        logic signed [COORD_W-1:0] y1;
    } edge_t;

    // Fields that bypass the divider
    typedef struct packed {
        logic                      neg;
        logic                      swapped;
        logic signed [COORD_W-1:0] x_start;
        logic signed [COORD_W-1:0] y_top;
        logic signed [COORD_W-1:0] y_bottom;
    } edge_tag_t;

    // Setup result handed to the scan converter
    typedef struct packed {
        logic signed [SLOPE_W-1:0] slope;
        logic signed [COORD_W-1:0] x_start;
        logic signed [COORD_W-1:0] y_top;
        logic signed [COORD_W-1:0] y_bottom;
        logic                      swapped;
        logic                      horizontal;
    } slope_t;

endpackage

`default_nettype wire
